// ==== source/xpu_pkg.sv ====
// xpu receive core shared widths, config register map and header word types
package xpu_pkg;

    // data path widths
    localparam int MAC_ADDR_WIDTH   = 48;
    localparam int TSF_WIDTH        = 64;
    localparam int CFG_ADDR_WIDTH   = 3;
    localparam int CFG_DATA_WIDTH   = 32;
    localparam int BYTE_COUNT_WIDTH = 16;

    // 100 MHz system clock
    localparam int CLK_PER_US  = 100;
    localparam int PRESC_WIDTH = $clog2(CLK_PER_US);

    // config register map
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_MAC_LO   = 3'd0;
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_MAC_HI   = 3'd1;
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_TSF_LO   = 3'd2;
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_TSF_HI   = 3'd3;
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_NAV_CTRL = 3'd4;

    // byte positions of the header fields inside the MPDU
    localparam int FC_DI_FIRST_BYTE = 0;
    localparam int FC_DI_LAST_BYTE  = 3;
    localparam int ADDR1_FIRST_BYTE = 4;
    localparam int ADDR1_LAST_BYTE  = 9;
    localparam int ADDR2_FIRST_BYTE = 10;
    localparam int ADDR2_LAST_BYTE  = 15;
    localparam int ADDR3_FIRST_BYTE = 16;
    localparam int ADDR3_LAST_BYTE  = 21;

    // frame control in the low half, duration in the high half
    typedef struct packed {
        logic [15:0] duration;
        logic        order;
        logic        protected_frame;
        logic        more_data;
        logic        power_manage;
        logic        retry;
        logic        more_frag;
        logic        from_ds;
        logic        to_ds;
        logic [3:0]  subtype;
        logic [1:0]  frame_type;
        logic [1:0]  version;
    } fc_fields_t;

    // byte 0 of the MPDU lands in bits 7:0
    typedef union packed {
        logic [31:0] raw;
        fc_fields_t  fields;
    } fc_di_t;

    // first received byte in bits 7:0
    typedef logic [MAC_ADDR_WIDTH-1:0] mac_addr_t;

    typedef logic [TSF_WIDTH-1:0] tsf_t;

    typedef struct packed {
        mac_addr_t own_mac;
        logic      nav_enable;
        tsf_t      tsf_load_val;
    } xpu_cfg_t;

endpackage

// ==== source/xpu_cfg_regs.sv ====
// xpu config registers, written by a plain strobe, with tsf load trigger detection
`timescale 1ns/1ps

module xpu_cfg_regs (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                cfg_wr_i,
    input  logic [xpu_pkg::CFG_ADDR_WIDTH-1:0]  cfg_addr_i,
    input  logic [xpu_pkg::CFG_DATA_WIDTH-1:0]  cfg_data_i,
    output xpu_pkg::xpu_cfg_t                   cfg_o,
    output logic                                tsf_load_o
);

    import xpu_pkg::*;

    localparam int MAC_HI_WIDTH = MAC_ADDR_WIDTH - CFG_DATA_WIDTH;
    localparam int TSF_HI_BITS  = TSF_WIDTH - CFG_DATA_WIDTH - 1;

    logic [CFG_DATA_WIDTH-1:0] mac_lo_q;
    logic [MAC_HI_WIDTH-1:0]   mac_hi_q;
    logic [CFG_DATA_WIDTH-1:0] tsf_lo_q;
    logic [CFG_DATA_WIDTH-1:0] tsf_hi_q;
    logic                      nav_dis_q;
    // previous value of the load trigger bit
    logic                      tsf_trig_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mac_lo_q   <= '0;
            mac_hi_q   <= '0;
            tsf_lo_q   <= '0;
            tsf_hi_q   <= '0;
            nav_dis_q  <= 1'b0;
            tsf_trig_q <= 1'b0;
        end else begin
            tsf_trig_q <= tsf_hi_q[CFG_DATA_WIDTH-1];
            if (cfg_wr_i) begin
                case (cfg_addr_i)
                    CFG_MAC_LO: begin
                        mac_lo_q <= cfg_data_i;
                    end
                    CFG_MAC_HI: begin
                        mac_hi_q <= cfg_data_i[MAC_HI_WIDTH-1:0];
                    end
                    CFG_TSF_LO: begin
                        tsf_lo_q <= cfg_data_i;
                    end
                    CFG_TSF_HI: begin
                        tsf_hi_q <= cfg_data_i;
                    end
                    CFG_NAV_CTRL: begin
                        nav_dis_q <= cfg_data_i[0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // rising edge of bit 31, one cycle after the write lands
    assign tsf_load_o = tsf_hi_q[CFG_DATA_WIDTH-1] & ~tsf_trig_q;

    assign cfg_o.own_mac      = {mac_hi_q, mac_lo_q};
    assign cfg_o.nav_enable   = ~nav_dis_q;
    // top bit of the timer always loads as zero
    assign cfg_o.tsf_load_val = {1'b0, tsf_hi_q[TSF_HI_BITS-1:0], tsf_lo_q};

endmodule

// ==== source/tsf_timer.sv ====
// tsf timer, 64-bit microsecond count with software load and 1 MHz pulse
`timescale 1ns/1ps

module tsf_timer (
    input  logic          clk,
    input  logic          reset_i,
    input  logic          tsf_load_i,
    input  xpu_pkg::tsf_t tsf_load_val_i,
    output xpu_pkg::tsf_t tsf_runtime_val_o,
    output logic          tsf_pulse_1m_o
);

    import xpu_pkg::*;

    logic [PRESC_WIDTH-1:0] presc_q;
    tsf_t                   tsf_q;
    logic                   pulse_q;
    logic                   presc_wrap;

    // last clock of the current microsecond
    assign presc_wrap = (presc_q == PRESC_WIDTH'(CLK_PER_US - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            presc_q <= '0;
            tsf_q   <= '0;
            pulse_q <= 1'b0;
        end else if (tsf_load_i) begin
            // restart the microsecond from the load point
            presc_q <= '0;
            tsf_q   <= tsf_load_val_i;
            pulse_q <= 1'b0;
        end else if (presc_wrap) begin
            presc_q <= '0;
            tsf_q   <= tsf_q + 1'b1;
            pulse_q <= 1'b1;
        end else begin
            presc_q <= presc_q + 1'b1;
            pulse_q <= 1'b0;
        end
    end

    assign tsf_runtime_val_o = tsf_q;
    assign tsf_pulse_1m_o    = pulse_q;

endmodule

// ==== source/phy_rx_parse.sv ====
// rx header parser, captures fc/duration and addr1-3 by byte index and matches addr1
`timescale 1ns/1ps

module phy_rx_parse (
    input  logic                                  clk,
    input  logic                                  reset_i,
    input  logic                                  pkt_header_valid_strobe_i,
    input  logic                                  byte_in_strobe_i,
    input  logic [7:0]                            byte_in_i,
    input  logic [xpu_pkg::BYTE_COUNT_WIDTH-1:0]  byte_count_i,
    input  xpu_pkg::mac_addr_t                    own_mac_i,
    output xpu_pkg::fc_di_t                       fc_di_o,
    output logic                                  fc_di_valid_o,
    output xpu_pkg::mac_addr_t                    addr1_o,
    output logic                                  addr1_valid_o,
    output xpu_pkg::mac_addr_t                    addr2_o,
    output logic                                  addr2_valid_o,
    output xpu_pkg::mac_addr_t                    addr3_o,
    output logic                                  addr3_valid_o,
    output logic                                  pkt_for_me_o
);

    import xpu_pkg::*;

    fc_di_t    fc_di_q;
    mac_addr_t addr1_q;
    mac_addr_t addr2_q;
    mac_addr_t addr3_q;
    logic      fc_di_valid_q;
    logic      addr1_valid_q;
    logic      addr2_valid_q;
    logic      addr3_valid_q;
    logic      pkt_for_me_q;

    // byte position inside each field
    logic [BYTE_COUNT_WIDTH-1:0] ofs_fc;
    logic [BYTE_COUNT_WIDTH-1:0] ofs_a1;
    logic [BYTE_COUNT_WIDTH-1:0] ofs_a2;
    logic [BYTE_COUNT_WIDTH-1:0] ofs_a3;

    function automatic logic in_field(input logic [BYTE_COUNT_WIDTH-1:0] idx,
                                      input int first, input int last);
        return (idx >= BYTE_COUNT_WIDTH'(first)) && (idx <= BYTE_COUNT_WIDTH'(last));
    endfunction

    assign ofs_fc = byte_count_i - BYTE_COUNT_WIDTH'(FC_DI_FIRST_BYTE);
    assign ofs_a1 = byte_count_i - BYTE_COUNT_WIDTH'(ADDR1_FIRST_BYTE);
    assign ofs_a2 = byte_count_i - BYTE_COUNT_WIDTH'(ADDR2_FIRST_BYTE);
    assign ofs_a3 = byte_count_i - BYTE_COUNT_WIDTH'(ADDR3_FIRST_BYTE);

    // new header clears everything from the previous packet
    always_ff @(posedge clk) begin
        if (reset_i || pkt_header_valid_strobe_i) begin
            fc_di_q       <= '0;
            addr1_q       <= '0;
            addr2_q       <= '0;
            addr3_q       <= '0;
            fc_di_valid_q <= 1'b0;
            addr1_valid_q <= 1'b0;
            addr2_valid_q <= 1'b0;
            addr3_valid_q <= 1'b0;
            pkt_for_me_q  <= 1'b0;
        end else begin
            fc_di_valid_q <= 1'b0;
            addr1_valid_q <= 1'b0;
            addr2_valid_q <= 1'b0;
            addr3_valid_q <= 1'b0;
            if (byte_in_strobe_i) begin
                if (in_field(byte_count_i, FC_DI_FIRST_BYTE, FC_DI_LAST_BYTE)) begin
                    fc_di_q.raw[8*ofs_fc[1:0] +: 8] <= byte_in_i;
                end
                if (in_field(byte_count_i, ADDR1_FIRST_BYTE, ADDR1_LAST_BYTE)) begin
                    addr1_q[8*ofs_a1[2:0] +: 8] <= byte_in_i;
                end
                if (in_field(byte_count_i, ADDR2_FIRST_BYTE, ADDR2_LAST_BYTE)) begin
                    addr2_q[8*ofs_a2[2:0] +: 8] <= byte_in_i;
                end
                if (in_field(byte_count_i, ADDR3_FIRST_BYTE, ADDR3_LAST_BYTE)) begin
                    addr3_q[8*ofs_a3[2:0] +: 8] <= byte_in_i;
                end
                fc_di_valid_q <= (byte_count_i == BYTE_COUNT_WIDTH'(FC_DI_LAST_BYTE));
                addr2_valid_q <= (byte_count_i == BYTE_COUNT_WIDTH'(ADDR2_LAST_BYTE));
                addr3_valid_q <= (byte_count_i == BYTE_COUNT_WIDTH'(ADDR3_LAST_BYTE));
                if (byte_count_i == BYTE_COUNT_WIDTH'(ADDR1_LAST_BYTE)) begin
                    addr1_valid_q <= 1'b1;
                    // last byte still on the input, compare the full address now
                    pkt_for_me_q  <= ({byte_in_i, addr1_q[MAC_ADDR_WIDTH-9:0]} == own_mac_i);
                end
            end
        end
    end

    assign fc_di_o       = fc_di_q;
    assign fc_di_valid_o = fc_di_valid_q;
    assign addr1_o       = addr1_q;
    assign addr1_valid_o = addr1_valid_q;
    assign addr2_o       = addr2_q;
    assign addr2_valid_o = addr2_valid_q;
    assign addr3_o       = addr3_q;
    assign addr3_valid_o = addr3_valid_q;
    assign pkt_for_me_o  = pkt_for_me_q;

endmodule

// ==== source/nav_fsm.sv ====
// nav state machine, holds the channel busy for an overheard duration
`timescale 1ns/1ps

module nav_fsm (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             nav_enable_i,
    input  xpu_pkg::fc_di_t  fc_di_i,
    input  logic             fc_di_valid_i,
    input  logic             pkt_for_me_i,
    input  logic             fcs_in_strobe_i,
    input  logic             fcs_ok_i,
    input  logic             pkt_header_valid_strobe_i,
    input  logic             tsf_pulse_1m_i,
    input  logic             demod_is_ongoing_i,
    output logic             ch_idle_o
);

    import xpu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_FCS,
        NAV_BUSY
    } nav_state_t;

    nav_state_t  state_q;
    nav_state_t  state_d;
    logic [15:0] remain_q;
    logic [15:0] remain_d;
    logic [15:0] pend_dur_q;
    // frame waiting for its fcs while the nav is already running
    logic        pend_busy_q;
    logic        pend_busy_d;
    logic        capture;
    logic        arm;
    logic        drop;

    // overheard frame with a plain duration, bit 15 marks aid or reserved
    assign capture = fc_di_valid_i && nav_enable_i && !pkt_for_me_i
                     && !fc_di_i.fields.duration[15];
    assign arm     = fcs_in_strobe_i && fcs_ok_i && !pkt_for_me_i;
    assign drop    = pkt_header_valid_strobe_i || pkt_for_me_i
                     || (fcs_in_strobe_i && !fcs_ok_i);

    always_comb begin
        state_d     = state_q;
        remain_d    = remain_q;
        pend_busy_d = pend_busy_q;
        case (state_q)
            IDLE: begin
                if (capture) begin
                    state_d = WAIT_FCS;
                end
            end
            WAIT_FCS: begin
                if (!nav_enable_i || drop) begin
                    state_d = IDLE;
                end else if (arm) begin
                    remain_d = pend_dur_q;
                    state_d  = (pend_dur_q == '0) ? IDLE : NAV_BUSY;
                end
            end
            NAV_BUSY: begin
                if (tsf_pulse_1m_i) begin
                    remain_d = remain_q - 1'b1;
                end
                // only a longer reservation extends the nav
                if (pend_busy_q && arm && (pend_dur_q > remain_d)) begin
                    remain_d = pend_dur_q;
                end
                if (capture) begin
                    pend_busy_d = 1'b1;
                end else if (drop || arm) begin
                    pend_busy_d = 1'b0;
                end
                if (!nav_enable_i) begin
                    state_d     = IDLE;
                    pend_busy_d = 1'b0;
                end else if (remain_d == '0) begin
                    state_d     = pend_busy_d ? WAIT_FCS : IDLE;
                    pend_busy_d = 1'b0;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q     <= IDLE;
            remain_q    <= '0;
            pend_busy_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            remain_q    <= remain_d;
            pend_busy_q <= pend_busy_d;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            pend_dur_q <= fc_di_i.fields.duration;
        end
    end

    assign ch_idle_o = (state_q != NAV_BUSY) && !demod_is_ongoing_i;

endmodule

// ==== source/xpu.sv ====
// xpu receive core top, config, tsf timer, header parser and nav
`timescale 1ns/1ps

module xpu (
    input  logic                                  clk,
    input  logic                                  reset_i,

    // config writes
    input  logic                                  cfg_wr_i,
    input  logic [xpu_pkg::CFG_ADDR_WIDTH-1:0]    cfg_addr_i,
    input  logic [xpu_pkg::CFG_DATA_WIDTH-1:0]    cfg_data_i,

    // from the demodulator
    input  logic                                  demod_is_ongoing_i,
    input  logic                                  pkt_header_valid_strobe_i,
    input  logic                                  byte_in_strobe_i,
    input  logic [7:0]                            byte_in_i,
    input  logic [xpu_pkg::BYTE_COUNT_WIDTH-1:0]  byte_count_i,
    input  logic                                  fcs_in_strobe_i,
    input  logic                                  fcs_ok_i,

    // side channel
    output logic [31:0]                           fc_di_o,
    output logic                                  fc_di_valid_o,
    output xpu_pkg::mac_addr_t                    addr1_o,
    output logic                                  addr1_valid_o,
    output xpu_pkg::mac_addr_t                    addr2_o,
    output logic                                  addr2_valid_o,
    output xpu_pkg::mac_addr_t                    addr3_o,
    output logic                                  addr3_valid_o,
    output logic                                  pkt_for_me_o,

    output xpu_pkg::tsf_t                         tsf_runtime_val_o,
    output logic                                  tsf_pulse_1m_o,
    output logic                                  ch_idle_o
);

    import xpu_pkg::*;

    xpu_cfg_t cfg;
    logic     tsf_load;
    fc_di_t   fc_di;
    logic     fc_di_valid;
    logic     pkt_for_me;
    logic     tsf_pulse_1m;

    xpu_cfg_regs u_cfg_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .cfg_wr_i   (cfg_wr_i),
        .cfg_addr_i (cfg_addr_i),
        .cfg_data_i (cfg_data_i),
        .cfg_o      (cfg),
        .tsf_load_o (tsf_load)
    );

    tsf_timer u_tsf_timer (
        .clk               (clk),
        .reset_i           (reset_i),
        .tsf_load_i        (tsf_load),
        .tsf_load_val_i    (cfg.tsf_load_val),
        .tsf_runtime_val_o (tsf_runtime_val_o),
        .tsf_pulse_1m_o    (tsf_pulse_1m)
    );

    phy_rx_parse u_phy_rx_parse (
        .clk                       (clk),
        .reset_i                   (reset_i),
        .pkt_header_valid_strobe_i (pkt_header_valid_strobe_i),
        .byte_in_strobe_i          (byte_in_strobe_i),
        .byte_in_i                 (byte_in_i),
        .byte_count_i              (byte_count_i),
        .own_mac_i                 (cfg.own_mac),
        .fc_di_o                   (fc_di),
        .fc_di_valid_o             (fc_di_valid),
        .addr1_o                   (addr1_o),
        .addr1_valid_o             (addr1_valid_o),
        .addr2_o                   (addr2_o),
        .addr2_valid_o             (addr2_valid_o),
        .addr3_o                   (addr3_o),
        .addr3_valid_o             (addr3_valid_o),
        .pkt_for_me_o              (pkt_for_me)
    );

    nav_fsm u_nav_fsm (
        .clk                       (clk),
        .reset_i                   (reset_i),
        .nav_enable_i              (cfg.nav_enable),
        .fc_di_i                   (fc_di),
        .fc_di_valid_i             (fc_di_valid),
        .pkt_for_me_i              (pkt_for_me),
        .fcs_in_strobe_i           (fcs_in_strobe_i),
        .fcs_ok_i                  (fcs_ok_i),
        .pkt_header_valid_strobe_i (pkt_header_valid_strobe_i),
        .tsf_pulse_1m_i            (tsf_pulse_1m),
        .demod_is_ongoing_i        (demod_is_ongoing_i),
        .ch_idle_o                 (ch_idle_o)
    );

    // raw view of the header word for the side channel
    assign fc_di_o        = fc_di.raw;
    assign fc_di_valid_o  = fc_di_valid;
    assign pkt_for_me_o   = pkt_for_me;
    assign tsf_pulse_1m_o = tsf_pulse_1m;

endmodule

// ==== verif/xpu_tb_tasks.svh ====
// directed xpu tests with the config, frame and random helpers they share
`ifndef XPU_TB_TASKS_SVH
`define XPU_TB_TASKS_SVH

// fibonacci lfsr x^32 + x^22 + x^2 + x + 1, one step per bit taken
function automatic logic [31:0] next_random(input int nbits);
    logic [31:0] r;
    int          k;
    r = '0;
    for (k = 0; k < nbits; k++) begin
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

function automatic mac_addr_t random_mac();
    logic [31:0] lo;
    logic [31:0] hi;
    lo = next_random(32);
    hi = next_random(16);
    return {hi[15:0], lo};
endfunction

// earliest byte lands in the low bits
function automatic logic [63:0] pack_bytes(input int first, input int n);
    logic [63:0] r;
    int          k;
    r = '0;
    for (k = n - 1; k >= 0; k--) begin
        r = {r[55:0], frame_bytes[first + k]};
    end
    return r;
endfunction

task automatic check_value(input string test_name, input logic [63:0] expected,
                           input logic [63:0] actual);
    checks = checks + 1;
    assert (actual === expected) else begin
        errors = errors + 1;
        $display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
    end
endtask

task automatic cfg_write(input logic [CFG_ADDR_WIDTH-1:0] addr,
                         input logic [CFG_DATA_WIDTH-1:0] data);
    @(posedge clk);
    cfg_wr_i   <= 1'b1;
    cfg_addr_i <= addr;
    cfg_data_i <= data;
    @(posedge clk);
    cfg_wr_i   <= 1'b0;
endtask

task automatic fill_frame(input logic [15:0] dur, input mac_addr_t a1);
    logic [31:0] r;
    int          k;
    for (k = 0; k < 22; k++) begin
        r = next_random(8);
        frame_bytes[k] = r[7:0];
    end
    frame_bytes[2] = dur[7:0];
    frame_bytes[3] = dur[15:8];
    for (k = 0; k < 6; k++) begin
        frame_bytes[4 + k] = a1[8*k +: 8];
    end
endtask

task automatic count_valids();
    fc_seen = fc_seen + int'(fc_di_valid_o);
    a1_seen = a1_seen + int'(addr1_valid_o);
    a2_seen = a2_seen + int'(addr2_valid_o);
    a3_seen = a3_seen + int'(addr3_valid_o);
    if (addr1_valid_o) begin
        me_at_a1 = pkt_for_me_o;
    end
endtask

// header strobe, then the 22 header bytes with consecutive indices
task automatic send_header();
    int i;
    fc_seen  = 0;
    a1_seen  = 0;
    a2_seen  = 0;
    a3_seen  = 0;
    me_at_a1 = 1'b0;
    @(posedge clk);
    demod_is_ongoing_i        <= 1'b1;
    pkt_header_valid_strobe_i <= 1'b1;
    @(posedge clk);
    pkt_header_valid_strobe_i <= 1'b0;
    for (i = 0; i < 22; i++) begin
        byte_in_strobe_i <= 1'b1;
        byte_in_i        <= frame_bytes[i];
        byte_count_i     <= BYTE_COUNT_WIDTH'(i);
        @(negedge clk);
        count_valids();
        @(posedge clk);
    end
    byte_in_strobe_i <= 1'b0;
    repeat (2) begin
        @(negedge clk);
        count_valids();
        @(posedge clk);
    end
endtask

// fcs strobe ends the frame and the demod activity, returns on the falling edge after it
task automatic end_frame(input logic ok);
    @(posedge clk);
    fcs_in_strobe_i <= 1'b1;
    fcs_ok_i        <= ok;
    @(negedge clk);
    // pulses from the arming edge on count down the nav
    arm_us = us_count;
    @(posedge clk);
    fcs_in_strobe_i    <= 1'b0;
    demod_is_ongoing_i <= 1'b0;
    @(negedge clk);
endtask

task automatic hold_idle(input string test_name);
    repeat (20) begin
        @(negedge clk);
        check_value(test_name, 64'd1, 64'(ch_idle_o));
    end
endtask

task automatic after_reset();
    @(negedge clk);
    check_value("after_reset valids", 64'd0,
                64'({fc_di_valid_o, addr1_valid_o, addr2_valid_o, addr3_valid_o}));
    check_value("after_reset pkt_for_me", 64'd0, 64'(pkt_for_me_o));
    check_value("after_reset ch_idle", 64'd1, 64'(ch_idle_o));
endtask

task automatic parse_header();
    logic [31:0] r;
    r = next_random(16);
    fill_frame(r[15:0], random_mac());
    send_header();
    check_value("parse fc_di", pack_bytes(0, 4), 64'(fc_di_o));
    check_value("parse addr1", pack_bytes(4, 6), 64'(addr1_o));
    check_value("parse addr2", pack_bytes(10, 6), 64'(addr2_o));
    check_value("parse addr3", pack_bytes(16, 6), 64'(addr3_o));
    check_value("parse valid pulses", 64'h1111, 64'({fc_seen[3:0], a1_seen[3:0],
                                                      a2_seen[3:0], a3_seen[3:0]}));
    end_frame(1'b0);
endtask

task automatic match_address();
    logic [31:0] r;
    own_mac = random_mac();
    cfg_write(CFG_MAC_LO, own_mac[31:0]);
    cfg_write(CFG_MAC_HI, {16'h0, own_mac[47:32]});
    fill_frame(16'd0, own_mac);
    send_header();
    check_value("match own at addr1_valid", 64'd1, 64'(me_at_a1));
    check_value("match own held", 64'd1, 64'(pkt_for_me_o));
    end_frame(1'b0);
    // one flipped bit anywhere in the address
    r = next_random(6);
    fill_frame(16'd0, own_mac ^ (48'd1 << (r % 48)));
    send_header();
    check_value("match other", 64'd0, 64'(pkt_for_me_o));
    end_frame(1'b0);
endtask

task automatic run_tsf();
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] r;
    tsf_t        load;
    int          base;
    int          last_cyc;
    int          seen;
    lo   = next_random(32);
    r    = next_random(31);
    hi   = {1'b1, r[30:0]};
    load = {1'b0, hi[30:0], lo};
    cfg_write(CFG_TSF_HI, {1'b0, hi[30:0]});
    cfg_write(CFG_TSF_LO, lo);
    cfg_write(CFG_TSF_HI, hi);
    // load lands two cycles after the strobe cycle
    @(posedge clk);
    @(negedge clk);
    base     = us_count;
    last_cyc = cycle_cnt;
    seen     = 0;
    check_value("tsf load", load, tsf_runtime_val_o);
    while (us_count - base < 3) begin
        @(negedge clk);
        check_value("tsf count", load + 64'(us_count - base), tsf_runtime_val_o);
        // one single-cycle pulse per microsecond, counted from the load
        check_value("tsf pulse", 64'(us_count - base != seen), 64'(tsf_pulse_1m_o));
        if (us_count - base != seen) begin
            check_value("tsf pulse period", 64'(CLK_PER_US), 64'(cycle_cnt - last_cyc));
            seen     = us_count - base;
            last_cyc = cycle_cnt;
        end
    end
    // trigger bit stays high, so no new edge
    cfg_write(CFG_TSF_HI, hi ^ 32'h0000_0f0f);
    while (us_count - base < 5) begin
        @(negedge clk);
        check_value("tsf no reload", load + 64'(us_count - base), tsf_runtime_val_o);
    end
endtask

task automatic nav_countdown();
    logic [31:0] r;
    int          dur;
    r   = next_random(2);
    dur = 2 + int'(r[1:0]);
    fill_frame(16'(dur), ~own_mac);
    send_header();
    end_frame(1'b1);
    check_value("nav armed", 64'd0, 64'(ch_idle_o));
    while (us_count - arm_us < dur) begin
        @(negedge clk);
        check_value("nav busy", 64'd0, 64'(ch_idle_o));
    end
    // nav sees the last pulse on the next edge
    @(negedge clk);
    check_value("nav end", 64'd1, 64'(ch_idle_o));
endtask

task automatic overheard_frame(input logic [15:0] dur, input mac_addr_t a1,
                               input logic ok, input string test_name);
    fill_frame(dur, a1);
    send_header();
    end_frame(ok);
    hold_idle(test_name);
endtask

task automatic nav_rejects();
    overheard_frame(16'd3, own_mac, 1'b1, "nav reject for me");
    overheard_frame(16'd3, ~own_mac, 1'b0, "nav reject bad fcs");
    overheard_frame(16'h8003, ~own_mac, 1'b1, "nav reject aid duration");
    cfg_write(CFG_NAV_CTRL, 32'd1);
    overheard_frame(16'd3, ~own_mac, 1'b1, "nav reject disabled");
    cfg_write(CFG_NAV_CTRL, 32'd0);
endtask

task automatic demod_follow();
    logic [31:0] r;
    int          k;
    for (k = 0; k < 8; k++) begin
        r = next_random(1);
        @(posedge clk);
        demod_is_ongoing_i <= r[0];
        @(negedge clk);
        check_value("demod_follow", 64'(!r[0]), 64'(ch_idle_o));
    end
    @(posedge clk);
    demod_is_ongoing_i <= 1'b0;
endtask

`endif

// ==== verif/tb_xpu.sv ====
// xpu receive core testbench top with clock, reset, DUT, random source and final report
`timescale 1ns/1ps

module tb_xpu;

    import xpu_pkg::*;

    // timer waits of all tests in microseconds, plus frame and config traffic
    localparam int US_WAITS       = 10;
    localparam int TIMEOUT_CYCLES = US_WAITS * CLK_PER_US + 3000;

    logic                        clk;
    logic                        reset_i;
    logic                        cfg_wr_i;
    logic [CFG_ADDR_WIDTH-1:0]   cfg_addr_i;
    logic [CFG_DATA_WIDTH-1:0]   cfg_data_i;
    logic                        demod_is_ongoing_i;
    logic                        pkt_header_valid_strobe_i;
    logic                        byte_in_strobe_i;
    logic [7:0]                  byte_in_i;
    logic [BYTE_COUNT_WIDTH-1:0] byte_count_i;
    logic                        fcs_in_strobe_i;
    logic                        fcs_ok_i;
    logic [31:0]                 fc_di_o;
    logic                        fc_di_valid_o;
    mac_addr_t                   addr1_o;
    logic                        addr1_valid_o;
    mac_addr_t                   addr2_o;
    logic                        addr2_valid_o;
    mac_addr_t                   addr3_o;
    logic                        addr3_valid_o;
    logic                        pkt_for_me_o;
    tsf_t                        tsf_runtime_val_o;
    logic                        tsf_pulse_1m_o;
    logic                        ch_idle_o;

    logic [31:0] lfsr_state = 32'h3a9;
    logic [7:0]  frame_bytes [22];
    mac_addr_t   own_mac;
    logic        me_at_a1;
    int          fc_seen;
    int          a1_seen;
    int          a2_seen;
    int          a3_seen;
    int          us_count;
    int          arm_us;
    int          checks;
    int          errors;
    int          cycle_cnt;

    xpu u_xpu (
        .clk                       (clk),
        .reset_i                   (reset_i),
        .cfg_wr_i                  (cfg_wr_i),
        .cfg_addr_i                (cfg_addr_i),
        .cfg_data_i                (cfg_data_i),
        .demod_is_ongoing_i        (demod_is_ongoing_i),
        .pkt_header_valid_strobe_i (pkt_header_valid_strobe_i),
        .byte_in_strobe_i          (byte_in_strobe_i),
        .byte_in_i                 (byte_in_i),
        .byte_count_i              (byte_count_i),
        .fcs_in_strobe_i           (fcs_in_strobe_i),
        .fcs_ok_i                  (fcs_ok_i),
        .fc_di_o                   (fc_di_o),
        .fc_di_valid_o             (fc_di_valid_o),
        .addr1_o                   (addr1_o),
        .addr1_valid_o             (addr1_valid_o),
        .addr2_o                   (addr2_o),
        .addr2_valid_o             (addr2_valid_o),
        .addr3_o                   (addr3_o),
        .addr3_valid_o             (addr3_valid_o),
        .pkt_for_me_o              (pkt_for_me_o),
        .tsf_runtime_val_o         (tsf_runtime_val_o),
        .tsf_pulse_1m_o            (tsf_pulse_1m_o),
        .ch_idle_o                 (ch_idle_o)
    );

    `include "xpu_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // microsecond pulses seen since time zero
    always @(posedge tsf_pulse_1m_o) begin
        us_count = us_count + 1;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        reset_i                   = 1'b1;
        cfg_wr_i                  = 1'b0;
        cfg_addr_i                = '0;
        cfg_data_i                = '0;
        demod_is_ongoing_i        = 1'b0;
        pkt_header_valid_strobe_i = 1'b0;
        byte_in_strobe_i          = 1'b0;
        byte_in_i                 = '0;
        byte_count_i              = '0;
        fcs_in_strobe_i           = 1'b0;
        fcs_ok_i                  = 1'b0;
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;

        after_reset();
        parse_header();
        match_address();
        run_tsf();
        nav_countdown();
        nav_rejects();
        demod_follow();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+verif
source/xpu_pkg.sv
source/xpu_cfg_regs.sv
source/tsf_timer.sv
source/phy_rx_parse.sv
source/nav_fsm.sv
source/xpu.sv
verif/tb_xpu.sv
